// ==== verilog/fir_ctrl_pkg.sv ====
package fir_ctrl_pkg;

	// Controller states of the command decoder
	// Idle waits for the first coefficient strobe after reset
	// Loading counts coefficients into the bank until it is full
	// Filtering accepts samples and turns coefficient strobes into restarts
	typedef enum logic [1:0] {
		state_idle      = 2'd0,
		state_loading   = 2'd1,
		state_filtering = 2'd2
	} fir_ctrl_state_t;

	// One command per cycle from the decoder to the tap MAC
	// No operation leaves the bank, the delay line and the sum untouched
	// Load coefficient shifts one more coefficient into the bank
	// Restart clears the bank and the delay line and takes a first coefficient
	// Push shifts a sample into the delay line and starts a new sum
	typedef enum logic [1:0] {
		op_nop        = 2'd0,
		op_load_coeff = 2'd1,
		op_restart    = 2'd2,
		op_push       = 2'd3
	} fir_opcode_t;

endpackage

// ==== verilog/fir_data_pkg.sv ====
package fir_data_pkg;

	// Unsigned input sample, also the width of the scaled output
	typedef logic [7:0] sample_t;

	// Unsigned filter coefficient
	typedef logic [7:0] coeff_t;

	// Right shift applied to the sum before saturation, 0 to 31
	typedef logic [4:0] shift_t;

	// Width of the full precision sum for a given number of taps
	// Each product needs 16 bits and every doubling of the tap count one more,
	// so the sum can never wrap
	function automatic int acc_width(input int taps);
		return 16 + $clog2(taps);
	endfunction

endpackage

// ==== verilog/fir_command_decoder.sv ====
`timescale 1ns/10ps

module fir_command_decoder
	import fir_ctrl_pkg::*, fir_data_pkg::*;
#(
	parameter int tap_count = 10
)(
	input  logic            clock,
	input  logic            rst_n,
	input  logic            load_coefficients_flag,
	input  logic            load_data_flag,
	input  coeff_t          coefficient_in,
	input  sample_t         data_in,
	output fir_opcode_t     opcode,
	output coeff_t          coefficient_data,
	output sample_t         sample_data,
	output logic            ready
);

	// Wide enough to hold the value tap_count itself
	localparam int count_width = $clog2(tap_count + 1);

	fir_ctrl_state_t state;

	// Number of coefficients taken since loading started
	logic [count_width-1:0] coefficient_count;
	logic [count_width-1:0] next_count;

	// Strobe decode
	// The coefficient strobe has priority when both strobes arrive together
	// In the filtering state a coefficient strobe means the bank is reloaded
	// from scratch, so it becomes a restart instead of a plain load
	always_comb begin
		opcode = op_nop;
		if (load_coefficients_flag) begin
			if (state == state_filtering) begin
				opcode = op_restart;
			end else begin
				opcode = op_load_coeff;
			end
		end else if (load_data_flag && (state == state_filtering)) begin
			// Samples are dropped until the bank is full
			opcode = op_push;
		end
	end

	// A restart counts its own coefficient as the first one
	always_comb begin
		if (opcode == op_restart) begin
			next_count = count_width'(1);
		end else begin
			next_count = coefficient_count + count_width'(1);
		end
	end

	// State and coefficient counter
	// The state moves to filtering on the same edge that takes the last
	// coefficient, which is what raises ready
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= state_idle;
			coefficient_count <= '0;
		end else begin
			case (opcode)
				op_load_coeff, op_restart: begin
					if (next_count == count_width'(tap_count)) begin
						state <= state_filtering;
						coefficient_count <= '0;
					end else begin
						state <= state_loading;
						coefficient_count <= next_count;
					end
				end
				default: begin
					// Push and no operation leave the sequencing alone
					state <= state;
				end
			endcase
		end
	end

	// Payload towards the MAC is forced to zero when the opcode does not use it,
	// so nothing downstream sees data from a rejected strobe
	always_comb begin
		if ((opcode == op_load_coeff) || (opcode == op_restart)) begin
			coefficient_data = coefficient_in;
		end else begin
			coefficient_data = '0;
		end
	end

	always_comb begin
		if (opcode == op_push) begin
			sample_data = data_in;
		end else begin
			sample_data = '0;
		end
	end

	// The bank is full exactly while filtering
	assign ready = (state == state_filtering);

endmodule

// ==== verilog/fir_tap_mac.sv ====
`timescale 1ns/10ps

module fir_tap_mac
	import fir_ctrl_pkg::*, fir_data_pkg::*;
#(
	parameter int tap_count = 10
)(
	input  logic                            clock,
	input  logic                            rst_n,
	input  fir_opcode_t                     opcode,
	input  coeff_t                          coefficient_data,
	input  sample_t                         sample_data,
	output logic [acc_width(tap_count)-1:0] sum,
	output logic                            sum_valid
);

	localparam int sum_width = acc_width(tap_count);

	// Coefficient bank
	// New coefficients enter at the top and move down, so after tap_count
	// loads the first loaded coefficient sits at index 0
	coeff_t coeff_bank [tap_count];

	// Stored samples, newest at index 0
	// Index k holds the sample that was pushed k+1 strobes ago
	sample_t sample_line [tap_count-1];

	// Taps seen by the multipliers
	// Tap 0 is the incoming sample, the rest come from the delay line
	sample_t window [tap_count];

	logic [sum_width-1:0] next_sum;

	always_comb begin
		window[0] = sample_data;
		for (int k = 1; k < tap_count; k++) begin
			window[k] = sample_line[k-1];
		end
	end

	// Multiply-accumulate over every tap
	// Each product is formed at 16 bits and then widened to the sum width
	always_comb begin
		logic [15:0] product;
		next_sum = '0;
		for (int k = 0; k < tap_count; k++) begin
			product = coeff_bank[k] * window[k];
			next_sum = next_sum + sum_width'(product);
		end
	end

	// Coefficient bank and delay line
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int k = 0; k < tap_count; k++) begin
				coeff_bank[k] <= '0;
			end
			for (int k = 0; k < tap_count - 1; k++) begin
				sample_line[k] <= '0;
			end
		end else begin
			case (opcode)
				op_load_coeff: begin
					for (int k = 0; k < tap_count - 1; k++) begin
						coeff_bank[k] <= coeff_bank[k+1];
					end
					coeff_bank[tap_count-1] <= coefficient_data;
				end
				op_restart: begin
					// Old coefficients and old samples are both discarded
					for (int k = 0; k < tap_count - 1; k++) begin
						coeff_bank[k] <= '0;
						sample_line[k] <= '0;
					end
					coeff_bank[tap_count-1] <= coefficient_data;
				end
				op_push: begin
					// The window already holds the shifted view of the line
					for (int k = 0; k < tap_count - 1; k++) begin
						sample_line[k] <= window[k];
					end
				end
				default: begin
					coeff_bank <= coeff_bank;
				end
			endcase
		end
	end

	// The sum is only meaningful while sum_valid is high
	always_ff @(posedge clock) begin
		if (opcode == op_push) begin
			sum <= next_sum;
		end
	end

	// One valid pulse per pushed sample
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= (opcode == op_push);
		end
	end

endmodule

// ==== verilog/fir_result_stage.sv ====
`timescale 1ns/10ps

module fir_result_stage
	import fir_data_pkg::*;
#(
	parameter int tap_count = 10
)(
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic [acc_width(tap_count)-1:0] sum,
	input  logic                            sum_valid,
	input  shift_t                          shift,
	output logic [acc_width(tap_count)-1:0] result,
	output sample_t                         scaled,
	output logic                            saturated,
	output logic                            result_valid
);

	localparam int sum_width = acc_width(tap_count);

	logic [sum_width-1:0] shifted;
	logic overflow;

	// Scale the sum down by the requested amount
	// Any bit left above the low byte means the value does not fit in 8 bits
	always_comb begin
		shifted = sum >> shift;
		overflow = |shifted[sum_width-1:8];
	end

	// Output registers, loaded only when a new sum arrives
	// The full sum is kept next to the scaled value for inspection
	always_ff @(posedge clock) begin
		if (sum_valid) begin
			result <= sum;
			saturated <= overflow;
			if (overflow) begin
				// Clamp to the largest 8-bit value
				scaled <= '1;
			end else begin
				scaled <= shifted[7:0];
			end
		end
	end

	// Valid follows the data by the same single register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= sum_valid;
		end
	end

endmodule

// ==== verilog/fir_filter_top.sv ====
`timescale 1ns/10ps

module fir_filter_top
	import fir_ctrl_pkg::*, fir_data_pkg::*;
#(
	parameter int tap_count = 10
)(
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            load_coefficients_flag,
	input  logic                            load_data_flag,
	input  coeff_t                          coefficient_in,
	input  sample_t                         data_in,
	input  shift_t                          shift,
	output logic                            ready,
	output logic [acc_width(tap_count)-1:0] result,
	output sample_t                         scaled,
	output logic                            saturated,
	output logic                            result_valid
);

	// Decoder to MAC
	fir_opcode_t opcode;
	coeff_t coefficient_data;
	sample_t sample_data;

	// MAC to result stage
	logic [acc_width(tap_count)-1:0] sum;
	logic sum_valid;

	// Decode stage turns the strobes into one opcode per cycle
	fir_command_decoder #(
		.tap_count (tap_count)
	) fir_command_decoder_inst (
		.clock                  (clock),
		.rst_n                  (rst_n),
		.load_coefficients_flag (load_coefficients_flag),
		.load_data_flag         (load_data_flag),
		.coefficient_in         (coefficient_in),
		.data_in                (data_in),
		.opcode                 (opcode),
		.coefficient_data       (coefficient_data),
		.sample_data            (sample_data),
		.ready                  (ready)
	);

	// Execute stage holds the bank and line and registers the sum
	fir_tap_mac #(
		.tap_count (tap_count)
	) fir_tap_mac_inst (
		.clock            (clock),
		.rst_n            (rst_n),
		.opcode           (opcode),
		.coefficient_data (coefficient_data),
		.sample_data      (sample_data),
		.sum              (sum),
		.sum_valid        (sum_valid)
	);

	// Result stage scales, clamps and registers the outputs
	fir_result_stage #(
		.tap_count (tap_count)
	) fir_result_stage_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.sum          (sum),
		.sum_valid    (sum_valid),
		.shift        (shift),
		.result       (result),
		.scaled       (scaled),
		.saturated    (saturated),
		.result_valid (result_valid)
	);

endmodule

// ==== verification/fir_filter_checker.sv ====
`timescale 1ns/10ps

module fir_filter_checker
	import fir_ctrl_pkg::*;
(
	input logic            clock,
	input logic            rst_n,
	input fir_opcode_t     opcode,
	input fir_ctrl_state_t state,
	input logic            ready,
	input logic            result_valid
);

	// A pushed sample goes through the MAC register and then the result register
	push_gives_result: assert property (
		@(posedge clock) disable iff (!rst_n)
		(opcode == op_push) |-> ##2 result_valid
	) else $error("result_valid missing two cycles after a push opcode");

	// The other direction, so that no result appears without a push
	result_needs_push: assert property (
		@(posedge clock) disable iff (!rst_n)
		result_valid |-> $past(opcode == op_push, 2)
	) else $error("result_valid without a push opcode two cycles earlier");

	// Reset empties the bank, so the filter is not ready and has nothing in flight
	reset_clears_outputs: assert property (
		@(posedge clock)
		!rst_n |=> (!ready && !result_valid)
	) else $error("ready or result_valid high right after reset");

	// Once the bank is full only a restart sends the controller back to loading
	filtering_is_sticky: assert property (
		@(posedge clock) disable iff (!rst_n)
		((state == state_filtering) && (opcode != op_restart)) |=> (state == state_filtering)
	) else $error("controller left the filtering state without a restart");

endmodule

// ==== verification/fir_filter_tb.sv ====
`timescale 1ns/10ps

module fir_filter_tb
	import fir_data_pkg::*;
();

	localparam int tap_count = 10;
	localparam int sum_width = acc_width(tap_count);
	// Cycles allowed for the last results to come out after the table ends
	localparam int drain_limit = 20;

	typedef enum logic [2:0] {
		act_idle,
		act_coeff,
		act_sample,
		act_restart,
		act_both
	} row_action_t;

	typedef struct {
		row_action_t action;
		sample_t     value;
		shift_t      shift;
	} stim_row_t;

	// One expected result and the cycle in which result_valid must be seen
	typedef struct {
		logic [sum_width-1:0] sum;
		sample_t              scaled;
		logic                 saturated;
		int                   cycle;
	} expected_t;

	logic clock;
	logic rst_n;
	logic load_coefficients_flag;
	logic load_data_flag;
	coeff_t coefficient_in;
	sample_t data_in;
	shift_t shift;
	logic ready;
	logic [sum_width-1:0] result;
	sample_t scaled;
	logic saturated;
	logic result_valid;

	stim_row_t stim_table[$];
	expected_t expected_results[$];
	// Index of the next expected result that the monitor will compare
	int results_seen;
	logic [15:0] lfsr_state;

	// Reference model state with the coefficients kept in load order
	coeff_t model_coeffs [tap_count];
	// Past samples of the model where model_line[0] is the one pushed by the previous strobe
	sample_t model_line [tap_count-1];
	int model_count;
	logic model_ready;
	logic model_active;
	// Sum waiting for the result edge, where shift gets applied
	logic stage_valid;
	logic [sum_width-1:0] stage_sum;
	int cycle_count;

	fir_filter_top #(
		.tap_count (tap_count)
	) fir_filter_top_inst (
		.clock                  (clock),
		.rst_n                  (rst_n),
		.load_coefficients_flag (load_coefficients_flag),
		.load_data_flag         (load_data_flag),
		.coefficient_in         (coefficient_in),
		.data_in                (data_in),
		.shift                  (shift),
		.ready                  (ready),
		.result                 (result),
		.scaled                 (scaled),
		.saturated              (saturated),
		.result_valid           (result_valid)
	);

	bind fir_filter_top fir_filter_checker fir_filter_checker_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.opcode       (opcode),
		.state        (fir_command_decoder_inst.state),
		.ready        (ready),
		.result_valid (result_valid)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// 16-bit Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit, so every byte costs eight steps
	function automatic sample_t random_byte();
		sample_t value;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[6:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sum(input string name, input logic [sum_width-1:0] got,
			input logic [sum_width-1:0] expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
				name, got, expected));
		end
	endtask

	task automatic check_scaled(input string name, input sample_t got, input sample_t expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
				name, got, expected));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
				name, got, expected));
		end
	endtask

	task automatic add_row(input row_action_t action, input sample_t value, input shift_t amount);
		stim_row_t row;
		row.action = action;
		row.value = value;
		row.shift = amount;
		stim_table.push_back(row);
	endtask

	task automatic build_table();
		// Samples before any coefficient must vanish, as must the one in the middle of
		// the load, and coefficient 5 arrives together with a data strobe
		for (int k = 0; k < 3; k++) begin
			add_row(act_sample, random_byte(), 5'd0);
		end
		for (int k = 1; k <= tap_count; k++) begin
			if (k == 5) begin
				add_row(act_both, 8'(k), 5'd0);
			end else begin
				add_row(act_coeff, 8'(k), 5'd0);
			end
			if (k == 3) begin
				add_row(act_sample, random_byte(), 5'd0);
			end
		end
		// An impulse makes the outputs replay 1 to 10 and then settle to zero
		add_row(act_sample, 8'd1, 5'd0);
		for (int k = 0; k < 12; k++) begin
			add_row(act_sample, 8'd0, 5'd0);
		end
		add_row(act_idle, 8'd0, 5'd3);
		// Back-to-back random samples keep two results in flight
		for (int k = 0; k < 20; k++) begin
			add_row(act_sample, random_byte(), 5'd3);
		end
		// Full scale bank and samples clamp at shift 0 and stay in range at shift 12
		add_row(act_restart, 8'hFF, 5'd0);
		for (int k = 0; k < tap_count - 1; k++) begin
			add_row(act_coeff, 8'hFF, 5'd0);
		end
		for (int k = 0; k < 12; k++) begin
			add_row(act_sample, 8'hFF, 5'd0);
		end
		for (int k = 0; k < 12; k++) begin
			add_row(act_sample, 8'hFF, 5'd12);
		end
		// A restart with a random bank must leave none of the old full scale samples
		add_row(act_restart, random_byte(), 5'd5);
		for (int k = 0; k < tap_count - 1; k++) begin
			add_row(act_coeff, random_byte(), 5'd5);
		end
		for (int k = 0; k < 15; k++) begin
			add_row(act_sample, random_byte(), 5'd5);
		end
		// Both strobes while filtering have to act as a restart
		add_row(act_both, random_byte(), 5'd7);
		for (int k = 0; k < tap_count - 1; k++) begin
			add_row(act_coeff, random_byte(), 5'd7);
		end
		for (int k = 0; k < 12; k++) begin
			add_row(act_sample, random_byte(), 5'd7);
		end
		for (int k = 0; k < 4; k++) begin
			add_row(act_idle, 8'd0, 5'd7);
		end
	endtask

	task automatic apply_row(input stim_row_t row);
		load_coefficients_flag = 1'b0;
		load_data_flag = 1'b0;
		shift = row.shift;
		case (row.action)
			act_coeff, act_restart: begin
				load_coefficients_flag = 1'b1;
				coefficient_in = row.value;
			end
			act_sample: begin
				load_data_flag = 1'b1;
				data_in = row.value;
			end
			act_both: begin
				load_coefficients_flag = 1'b1;
				load_data_flag = 1'b1;
				coefficient_in = row.value;
				data_in = ~row.value;
			end
			default: begin
				// Idle keeps both strobes low
			end
		endcase
	endtask

	// Sum over the taps with the new sample against the first loaded coefficient
	function automatic logic [sum_width-1:0] expected_sum(input sample_t sample);
		logic [sum_width-1:0] total;
		total = sum_width'(model_coeffs[0]) * sum_width'(sample);
		for (int k = 1; k < tap_count; k++) begin
			total = total + sum_width'(model_coeffs[k]) * sum_width'(model_line[k-1]);
		end
		return total;
	endfunction

	// The reference model samples the inputs it drove at each rising edge
	always @(posedge clock) begin
		expected_t entry;
		logic [sum_width-1:0] shifted;
		if (!rst_n) begin
			model_coeffs = '{default: '0};
			model_line = '{default: '0};
			model_count = 0;
			model_ready = 1'b0;
			model_active = 1'b0;
			stage_valid = 1'b0;
			cycle_count = 0;
		end else begin
			model_active = 1'b1;
			cycle_count++;
			// The pending sum meets the shift value present at this edge
			if (stage_valid) begin
				shifted = stage_sum >> shift;
				entry.sum = stage_sum;
				entry.saturated = (shifted > sum_width'(255));
				entry.scaled = entry.saturated ? 8'hFF : shifted[7:0];
				entry.cycle = cycle_count;
				expected_results.push_back(entry);
			end
			stage_valid = 1'b0;
			if (load_coefficients_flag) begin
				if (model_ready) begin
					// A restart discards everything loaded or stored so far
					model_coeffs = '{default: '0};
					model_line = '{default: '0};
					model_ready = 1'b0;
					model_count = 0;
				end
				model_coeffs[model_count] = coefficient_in;
				model_count++;
				if (model_count == tap_count) begin
					model_ready = 1'b1;
					model_count = 0;
				end
			end else if (load_data_flag && model_ready) begin
				stage_sum = expected_sum(data_in);
				stage_valid = 1'b1;
				for (int k = tap_count - 2; k > 0; k--) begin
					model_line[k] = model_line[k-1];
				end
				model_line[0] = data_in;
			end
		end
	end

	// Monitor on the falling edge, where the registered outputs are settled
	always @(negedge clock) begin
		expected_t head;
		if (model_active === 1'b1) begin
			check_flag("ready", ready, model_ready);
			if (result_valid === 1'b1) begin
				if (results_seen >= expected_results.size()) begin
					stop_with_failure("result_valid pulsed while no sample was pending");
				end else begin
					head = expected_results[results_seen];
					results_seen++;
					check_sum("result", result, head.sum);
					check_scaled("scaled", scaled, head.scaled);
					check_flag("saturated", saturated, head.saturated);
				end
			end else if (result_valid !== 1'b0) begin
				stop_with_failure("result_valid is neither high nor low");
			end else if ((results_seen < expected_results.size()) &&
					(expected_results[results_seen].cycle <= cycle_count)) begin
				stop_with_failure("a result did not appear two cycles after its sample");
			end
		end
	end

	initial begin
		int waited;
		rst_n = 1'b0;
		load_coefficients_flag = 1'b0;
		load_data_flag = 1'b0;
		coefficient_in = '0;
		data_in = '0;
		shift = '0;
		lfsr_state = 16'd18;
		build_table();
		repeat (10) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		foreach (stim_table[i]) begin
			@(negedge clock);
			apply_row(stim_table[i]);
		end
		// Let the results still in the pipeline come out
		waited = 0;
		while (((results_seen < expected_results.size()) || stage_valid) &&
				(waited < drain_limit)) begin
			@(negedge clock);
			waited++;
		end
		if ((results_seen == expected_results.size()) && !stage_valid) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			stop_with_failure("timed out waiting for the last results");
		end
	end

endmodule

// ==== src.f ====
verilog/fir_ctrl_pkg.sv
verilog/fir_data_pkg.sv
verilog/fir_command_decoder.sv
verilog/fir_tap_mac.sv
verilog/fir_result_stage.sv
verilog/fir_filter_top.sv
verification/fir_filter_checker.sv
verification/fir_filter_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = fir_filter_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the simulation printed the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
